// ==== hdl/icache_ctrl_pkg.sv ====
// Sizes, register map and encodings shared by the cache control unit; import by wildcard
package icache_ctrl_pkg;

   // Private L1 caches, one per core
   localparam int unsigned NB_CORES = 8;

   // Shared L2 banks
   localparam int unsigned NB_BANKS = 4;

   // Transaction id carried from request to response on the peripheral port
   localparam int unsigned ID_WIDTH = 5;

   // Word offsets decoded from address bits 5..2

   // Bank enable mask, a write enables the banks with a 1 and disables the rest
   localparam logic [3:0] REG_ENABLE    = 4'd0;

   // Any write flushes every L2 bank
   localparam logic [3:0] REG_FLUSH_L2  = 4'd1;

   // Mask of L1 caches to flush
   localparam logic [3:0] REG_FLUSH_L1  = 4'd2;

   // Address flushed in every cache level
   localparam logic [3:0] REG_SEL_FLUSH = 4'd3;

   // Mask of L1 caches put in bypass
   localparam logic [3:0] REG_BYPASS    = 4'd7;

   // Per-core L1 to L1.5 prefetch enables
   localparam logic [3:0] REG_PREFETCH  = 4'd8;

   // Bit 0 holds the special-core cache configuration
   localparam logic [3:0] REG_SPECIAL   = 4'd9;

   // Commands passed from the register stage to the sequencer
   typedef enum logic [2:0]
   {
      CMD_ENABLE    = 3'd0,
      CMD_FLUSH_L2  = 3'd1,
      CMD_FLUSH_L1  = 3'd2,
      CMD_SEL_FLUSH = 3'd3,
      CMD_BYPASS    = 3'd4
   } icache_cmd_e;

   // Sequencer FSM states
   typedef enum logic [1:0]
   {
      SEQ_IDLE = 2'd0,
      SEQ_WAIT = 2'd1
   } seq_state_e;

endpackage

// ==== hdl/icache_ctrl_regs.sv ====
// First stage of the cache control unit, grants port accesses, holds config and issues commands
module icache_ctrl_regs import icache_ctrl_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   input  logic                req_i,
   input  logic                wen_i,
   input  logic [31:0]         addr_i,
   input  logic [31:0]         wdata_i,
   input  logic [3:0]          be_i,
   input  logic [ID_WIDTH-1:0] id_i,
   output logic                gnt_o,
   output logic                r_valid_o,
   output logic                r_opc_o,
   output logic [ID_WIDTH-1:0] r_id_o,
   output logic [31:0]         r_rdata_o,

   input  logic                seq_busy_i,
   output logic                cmd_valid_o,
   output icache_cmd_e         cmd_op_o,
   output logic [31:0]         cmd_arg_o,

   output logic [NB_CORES-1:0] prefetch_en_o,
   output logic                special_cfg_o
);

   logic [3:0]          offset;
   logic                wr_en;
   logic                mapped;
   logic                is_cmd;
   icache_cmd_e         op_d;
   logic [31:0]         wr_val;
   logic [31:0]         rdata_d;

   logic [NB_BANKS-1:0] enable_q;
   logic [NB_CORES-1:0] bypass_q;
   logic [31:0]         sel_addr_q;
   logic [NB_CORES-1:0] prefetch_q;
   logic                special_q;

   logic                cmd_valid_q;
   icache_cmd_e         cmd_op_q;
   logic [31:0]         cmd_arg_q;

   logic                r_valid_q;
   logic                r_opc_q;
   logic [ID_WIDTH-1:0] r_id_q;
   logic [31:0]         r_rdata_q;

   // Bytes with a low enable keep their old value
   function automatic logic [31:0] merge_be(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [3:0]  be);
      logic [31:0] mask;
      for (int b = 0; b < 4; b++)
      begin
         mask[b*8 +: 8] = {8{be[b]}};
      end
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   assign offset = addr_i[5:2];

   // One access at a time while a command is in flight
   assign gnt_o = req_i & ~cmd_valid_q & ~seq_busy_i;
   assign wr_en = gnt_o & ~wen_i;

   always_comb
   begin
      mapped  = 1'b1;
      is_cmd  = 1'b0;
      op_d    = CMD_ENABLE;
      wr_val  = '0;
      rdata_d = '0;
      case (offset)
         REG_ENABLE:
         begin
            is_cmd  = 1'b1;
            wr_val  = merge_be(32'(enable_q), wdata_i, be_i);
            rdata_d = 32'(enable_q);
         end
         REG_FLUSH_L2:
         begin
            is_cmd = 1'b1;
            op_d   = CMD_FLUSH_L2;
         end
         REG_FLUSH_L1:
         begin
            is_cmd = 1'b1;
            op_d   = CMD_FLUSH_L1;
            wr_val = merge_be('0, wdata_i, be_i);
         end
         REG_SEL_FLUSH:
         begin
            is_cmd  = 1'b1;
            op_d    = CMD_SEL_FLUSH;
            wr_val  = merge_be(sel_addr_q, wdata_i, be_i);
            rdata_d = sel_addr_q;
         end
         REG_BYPASS:
         begin
            is_cmd  = 1'b1;
            op_d    = CMD_BYPASS;
            wr_val  = merge_be(32'(bypass_q), wdata_i, be_i);
            rdata_d = 32'(bypass_q);
         end
         REG_PREFETCH:
         begin
            wr_val  = merge_be(32'(prefetch_q), wdata_i, be_i);
            rdata_d = 32'(prefetch_q);
         end
         REG_SPECIAL:
         begin
            wr_val  = merge_be(32'(special_q), wdata_i, be_i);
            rdata_d = 32'(special_q);
         end
         default:
         begin
            mapped = 1'b0;
         end
      endcase
      // Writes answer with zero data
      if (!wen_i)
      begin
         rdata_d = '0;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         enable_q    <= '0;
         bypass_q    <= '0;
         sel_addr_q  <= '0;
         prefetch_q  <= '0;
         special_q   <= 1'b0;
         cmd_valid_q <= 1'b0;
         r_valid_q   <= 1'b0;
      end
      else
      begin
         cmd_valid_q <= wr_en & is_cmd;
         r_valid_q   <= gnt_o;
         if (wr_en)
         begin
            case (offset)
               REG_ENABLE:    enable_q   <= wr_val[NB_BANKS-1:0];
               REG_SEL_FLUSH: sel_addr_q <= wr_val;
               REG_BYPASS:    bypass_q   <= wr_val[NB_CORES-1:0];
               REG_PREFETCH:  prefetch_q <= wr_val[NB_CORES-1:0];
               REG_SPECIAL:   special_q  <= wr_val[0];
               default:       ;
            endcase
         end
      end
   end

   // Response and command payload, qualified by their valid flags
   always_ff @(posedge clk_i)
   begin
      if (gnt_o)
      begin
         r_id_q    <= id_i;
         r_opc_q   <= ~mapped;
         r_rdata_q <= rdata_d;
      end
      if (wr_en && is_cmd)
      begin
         cmd_op_q  <= op_d;
         cmd_arg_q <= wr_val;
      end
   end

   assign r_valid_o     = r_valid_q;
   assign r_opc_o       = r_opc_q;
   assign r_id_o        = r_id_q;
   assign r_rdata_o     = r_rdata_q;
   assign cmd_valid_o   = cmd_valid_q;
   assign cmd_op_o      = cmd_op_q;
   assign cmd_arg_o     = cmd_arg_q;
   assign prefetch_en_o = prefetch_q;
   assign special_cfg_o = special_q;

endmodule

// ==== hdl/icache_ctrl_seq.sv ====
// Second stage of the cache control unit, raises cache request lines and retires on their acks
module icache_ctrl_seq import icache_ctrl_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   input  logic                cmd_valid_i,
   input  icache_cmd_e         cmd_op_i,
   input  logic [31:0]         cmd_arg_i,
   output logic                busy_o,

   output logic [NB_CORES-1:0] l1_bypass_req_o,
   output logic [NB_CORES-1:0] l1_flush_req_o,
   output logic [NB_CORES-1:0] l1_sel_flush_req_o,
   input  logic [NB_CORES-1:0] l1_bypass_ack_i,
   input  logic [NB_CORES-1:0] l1_flush_ack_i,
   input  logic [NB_CORES-1:0] l1_sel_flush_ack_i,

   output logic [NB_BANKS-1:0] l2_enable_req_o,
   output logic [NB_BANKS-1:0] l2_disable_req_o,
   output logic [NB_BANKS-1:0] l2_flush_req_o,
   output logic [NB_BANKS-1:0] l2_sel_flush_req_o,
   input  logic [NB_BANKS-1:0] l2_enable_ack_i,
   input  logic [NB_BANKS-1:0] l2_disable_ack_i,
   input  logic [NB_BANKS-1:0] l2_flush_ack_i,
   input  logic [NB_BANKS-1:0] l2_sel_flush_ack_i,

   output logic [31:0]         sel_flush_addr_o
);

   seq_state_e          state_q;

   // Pending bits double as the request lines
   logic [NB_CORES-1:0] l1_bypass_q;
   logic [NB_CORES-1:0] l1_flush_q;
   logic [NB_CORES-1:0] l1_sel_q;
   logic [NB_BANKS-1:0] l2_enable_q;
   logic [NB_BANKS-1:0] l2_disable_q;
   logic [NB_BANKS-1:0] l2_flush_q;
   logic [NB_BANKS-1:0] l2_sel_q;
   logic [31:0]         sel_flush_addr_q;

   logic [NB_CORES-1:0] l1_bypass_left;
   logic [NB_CORES-1:0] l1_flush_left;
   logic [NB_CORES-1:0] l1_sel_left;
   logic [NB_BANKS-1:0] l2_enable_left;
   logic [NB_BANKS-1:0] l2_disable_left;
   logic [NB_BANKS-1:0] l2_flush_left;
   logic [NB_BANKS-1:0] l2_sel_left;
   logic                all_done;

   // What is still pending once this cycle's acks are taken
   always_comb
   begin
      l1_bypass_left  = l1_bypass_q & ~l1_bypass_ack_i;
      l1_flush_left   = l1_flush_q & ~l1_flush_ack_i;
      l1_sel_left     = l1_sel_q & ~l1_sel_flush_ack_i;
      l2_enable_left  = l2_enable_q & ~l2_enable_ack_i;
      l2_disable_left = l2_disable_q & ~l2_disable_ack_i;
      l2_flush_left   = l2_flush_q & ~l2_flush_ack_i;
      l2_sel_left     = l2_sel_q & ~l2_sel_flush_ack_i;
      all_done        = ~|{l1_bypass_left, l1_flush_left, l1_sel_left,
                           l2_enable_left, l2_disable_left, l2_flush_left, l2_sel_left};
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q      <= SEQ_IDLE;
         l1_bypass_q  <= '0;
         l1_flush_q   <= '0;
         l1_sel_q     <= '0;
         l2_enable_q  <= '0;
         l2_disable_q <= '0;
         l2_flush_q   <= '0;
         l2_sel_q     <= '0;
      end
      else
      begin
         case (state_q)
            SEQ_IDLE:
            begin
               // An empty mask still passes through SEQ_WAIT for one cycle
               if (cmd_valid_i)
               begin
                  state_q <= SEQ_WAIT;
                  case (cmd_op_i)
                     CMD_ENABLE:
                     begin
                        l2_enable_q  <= cmd_arg_i[NB_BANKS-1:0];
                        l2_disable_q <= ~cmd_arg_i[NB_BANKS-1:0];
                     end
                     CMD_FLUSH_L2:
                     begin
                        l2_flush_q <= '1;
                     end
                     CMD_FLUSH_L1:
                     begin
                        l1_flush_q <= cmd_arg_i[NB_CORES-1:0];
                     end
                     CMD_SEL_FLUSH:
                     begin
                        l1_sel_q <= '1;
                        l2_sel_q <= '1;
                     end
                     CMD_BYPASS:
                     begin
                        l1_bypass_q <= cmd_arg_i[NB_CORES-1:0];
                     end
                     default:
                     begin
                        l1_bypass_q <= '0;
                     end
                  endcase
               end
            end
            SEQ_WAIT:
            begin
               l1_bypass_q  <= l1_bypass_left;
               l1_flush_q   <= l1_flush_left;
               l1_sel_q     <= l1_sel_left;
               l2_enable_q  <= l2_enable_left;
               l2_disable_q <= l2_disable_left;
               l2_flush_q   <= l2_flush_left;
               l2_sel_q     <= l2_sel_left;
               if (all_done)
               begin
                  state_q <= SEQ_IDLE;
               end
            end
            default:
            begin
               state_q <= SEQ_IDLE;
            end
         endcase
      end
   end

   // Held from the load until the next selective flush
   always_ff @(posedge clk_i)
   begin
      if (state_q == SEQ_IDLE && cmd_valid_i && cmd_op_i == CMD_SEL_FLUSH)
      begin
         sel_flush_addr_q <= cmd_arg_i;
      end
   end

   assign busy_o             = (state_q == SEQ_WAIT);
   assign l1_bypass_req_o    = l1_bypass_q;
   assign l1_flush_req_o     = l1_flush_q;
   assign l1_sel_flush_req_o = l1_sel_q;
   assign l2_enable_req_o    = l2_enable_q;
   assign l2_disable_req_o   = l2_disable_q;
   assign l2_flush_req_o     = l2_flush_q;
   assign l2_sel_flush_req_o = l2_sel_q;
   assign sel_flush_addr_o   = sel_flush_addr_q;

endmodule

// ==== hdl/icache_ctrl_top.sv ====
// Top level of the instruction cache control unit, peripheral port in and cache lines out
module icache_ctrl_top import icache_ctrl_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   input  logic                req_i,
   input  logic                wen_i,
   input  logic [31:0]         addr_i,
   input  logic [31:0]         wdata_i,
   input  logic [3:0]          be_i,
   input  logic [ID_WIDTH-1:0] id_i,
   output logic                gnt_o,
   output logic                r_valid_o,
   output logic                r_opc_o,
   output logic [ID_WIDTH-1:0] r_id_o,
   output logic [31:0]         r_rdata_o,

   output logic [NB_CORES-1:0] l1_bypass_req_o,
   output logic [NB_CORES-1:0] l1_flush_req_o,
   output logic [NB_CORES-1:0] l1_sel_flush_req_o,
   input  logic [NB_CORES-1:0] l1_bypass_ack_i,
   input  logic [NB_CORES-1:0] l1_flush_ack_i,
   input  logic [NB_CORES-1:0] l1_sel_flush_ack_i,

   output logic [NB_BANKS-1:0] l2_enable_req_o,
   output logic [NB_BANKS-1:0] l2_disable_req_o,
   output logic [NB_BANKS-1:0] l2_flush_req_o,
   output logic [NB_BANKS-1:0] l2_sel_flush_req_o,
   input  logic [NB_BANKS-1:0] l2_enable_ack_i,
   input  logic [NB_BANKS-1:0] l2_disable_ack_i,
   input  logic [NB_BANKS-1:0] l2_flush_ack_i,
   input  logic [NB_BANKS-1:0] l2_sel_flush_ack_i,
   output logic [31:0]         sel_flush_addr_o,

   output logic [NB_CORES-1:0] prefetch_en_o,
   output logic                special_cfg_o
);

   logic        cmd_valid;
   icache_cmd_e cmd_op;
   logic [31:0] cmd_arg;
   logic        seq_busy;

   icache_ctrl_regs u_regs
   (
      .clk_i         ( clk_i         ),
      .arst_n_i      ( arst_n_i      ),
      .req_i         ( req_i         ),
      .wen_i         ( wen_i         ),
      .addr_i        ( addr_i        ),
      .wdata_i       ( wdata_i       ),
      .be_i          ( be_i          ),
      .id_i          ( id_i          ),
      .gnt_o         ( gnt_o         ),
      .r_valid_o     ( r_valid_o     ),
      .r_opc_o       ( r_opc_o       ),
      .r_id_o        ( r_id_o        ),
      .r_rdata_o     ( r_rdata_o     ),
      .seq_busy_i    ( seq_busy      ),
      .cmd_valid_o   ( cmd_valid     ),
      .cmd_op_o      ( cmd_op        ),
      .cmd_arg_o     ( cmd_arg       ),
      .prefetch_en_o ( prefetch_en_o ),
      .special_cfg_o ( special_cfg_o )
   );

   icache_ctrl_seq u_seq
   (
      .clk_i              ( clk_i              ),
      .arst_n_i           ( arst_n_i           ),
      .cmd_valid_i        ( cmd_valid          ),
      .cmd_op_i           ( cmd_op             ),
      .cmd_arg_i          ( cmd_arg            ),
      .busy_o             ( seq_busy           ),
      .l1_bypass_req_o    ( l1_bypass_req_o    ),
      .l1_flush_req_o     ( l1_flush_req_o     ),
      .l1_sel_flush_req_o ( l1_sel_flush_req_o ),
      .l1_bypass_ack_i    ( l1_bypass_ack_i    ),
      .l1_flush_ack_i     ( l1_flush_ack_i     ),
      .l1_sel_flush_ack_i ( l1_sel_flush_ack_i ),
      .l2_enable_req_o    ( l2_enable_req_o    ),
      .l2_disable_req_o   ( l2_disable_req_o   ),
      .l2_flush_req_o     ( l2_flush_req_o     ),
      .l2_sel_flush_req_o ( l2_sel_flush_req_o ),
      .l2_enable_ack_i    ( l2_enable_ack_i    ),
      .l2_disable_ack_i   ( l2_disable_ack_i   ),
      .l2_flush_ack_i     ( l2_flush_ack_i     ),
      .l2_sel_flush_ack_i ( l2_sel_flush_ack_i ),
      .sel_flush_addr_o   ( sel_flush_addr_o   )
   );

endmodule

// ==== test/icache_ctrl_props.sv ====
// Protocol assertions for the cache control unit, bound into the top level
module icache_ctrl_props import icache_ctrl_pkg::*;
(
   input logic                             clk_i,
   input logic                             arst_n_i,
   input logic                             gnt_i,
   input logic [ID_WIDTH-1:0]              id_i,
   input logic                             r_valid_i,
   input logic [ID_WIDTH-1:0]              r_id_i,
   input logic [NB_BANKS-1:0]              l2_enable_req_i,
   input logic [NB_BANKS-1:0]              l2_disable_req_i,
   input logic                             sel_busy_i,
   input logic [31:0]                      sel_flush_addr_i,
   input logic [3*NB_CORES+4*NB_BANKS-1:0] req_lines_i,
   input logic [3*NB_CORES+4*NB_BANKS-1:0] ack_lines_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;

   a_resp_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      gnt_i |=> r_valid_i && r_id_i == $past(id_i))
   else
   begin
      fail_count++;
      $error("response missing or with a wrong id one cycle after a grant");
   end

   // A line may only drop on the edge after its ack was sampled
   a_hold_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (~req_lines_i & $past(req_lines_i & ~ack_lines_i)) == '0)
   else
   begin
      fail_count++;
      $error("cache request dropped before its ack");
   end

   a_enable_xor_disable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (l2_enable_req_i & l2_disable_req_i) == '0)
   else
   begin
      fail_count++;
      $error("enable and disable requested together on one bank");
   end

   a_sel_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      sel_busy_i |=> !sel_busy_i || $stable(sel_flush_addr_i))
   else
   begin
      fail_count++;
      $error("selective flush address changed during the flush");
   end

   a_no_gnt_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (|req_lines_i) |-> !gnt_i)
   else
   begin
      fail_count++;
      $error("port granted while a cache request is pending");
   end

endmodule

bind icache_ctrl_top icache_ctrl_props u_props
(
   .clk_i            ( clk_i                                                   ),
   .arst_n_i         ( arst_n_i                                                ),
   .gnt_i            ( gnt_o                                                   ),
   .id_i             ( id_i                                                    ),
   .r_valid_i        ( r_valid_o                                               ),
   .r_id_i           ( r_id_o                                                  ),
   .l2_enable_req_i  ( l2_enable_req_o                                         ),
   .l2_disable_req_i ( l2_disable_req_o                                        ),
   .sel_busy_i       ( |{l1_sel_flush_req_o, l2_sel_flush_req_o}               ),
   .sel_flush_addr_i ( sel_flush_addr_o                                        ),
   .req_lines_i      ( {l1_bypass_req_o, l1_flush_req_o, l1_sel_flush_req_o,
                        l2_enable_req_o, l2_disable_req_o, l2_flush_req_o,
                        l2_sel_flush_req_o}                                    ),
   .ack_lines_i      ( {l1_bypass_ack_i, l1_flush_ack_i, l1_sel_flush_ack_i,
                        l2_enable_ack_i, l2_disable_ack_i, l2_flush_ack_i,
                        l2_sel_flush_ack_i}                                    )
);

// ==== test/icache_ctrl_tb.sv ====
// Testbench for the cache control unit that drives the register port and answers the cache requests
module icache_ctrl_tb import icache_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic                clk = 1'b0;
   logic                arst_n;
   logic                req;
   logic                wen;
   logic [31:0]         addr;
   logic [31:0]         wdata;
   logic [3:0]          be;
   logic [ID_WIDTH-1:0] id;
   logic                gnt;
   logic                r_valid;
   logic                r_opc;
   logic [ID_WIDTH-1:0] r_id;
   logic [31:0]         r_rdata;
   logic [NB_CORES-1:0] l1_bypass_req;
   logic [NB_CORES-1:0] l1_flush_req;
   logic [NB_CORES-1:0] l1_sel_flush_req;
   logic [NB_CORES-1:0] l1_bypass_ack;
   logic [NB_CORES-1:0] l1_flush_ack;
   logic [NB_CORES-1:0] l1_sel_flush_ack;
   logic [NB_BANKS-1:0] l2_enable_req;
   logic [NB_BANKS-1:0] l2_disable_req;
   logic [NB_BANKS-1:0] l2_flush_req;
   logic [NB_BANKS-1:0] l2_sel_flush_req;
   logic [NB_BANKS-1:0] l2_enable_ack;
   logic [NB_BANKS-1:0] l2_disable_ack;
   logic [NB_BANKS-1:0] l2_flush_ack;
   logic [NB_BANKS-1:0] l2_sel_flush_ack;
   logic [31:0]         sel_flush_addr;
   logic [NB_CORES-1:0] prefetch_en;
   logic                special_cfg;

   logic                granted;
   bit                  hung;
   int                  errors;
   int                  errors_at_start;
   int                  tests_run;
   int                  tests_failed;
   logic [NB_CORES-1:0] pf_exp;
   logic                sp_exp;

   always #20 clk = ~clk;

   // A grant seen at a rising edge becomes visible to the port driver half a cycle later
   always @(posedge clk)
   begin
      granted <= gnt;
   end

   icache_ctrl_top u_dut
   (
      .clk_i              ( clk              ),
      .arst_n_i           ( arst_n           ),
      .req_i              ( req              ),
      .wen_i              ( wen              ),
      .addr_i             ( addr             ),
      .wdata_i            ( wdata            ),
      .be_i               ( be               ),
      .id_i               ( id               ),
      .gnt_o              ( gnt              ),
      .r_valid_o          ( r_valid          ),
      .r_opc_o            ( r_opc            ),
      .r_id_o             ( r_id             ),
      .r_rdata_o          ( r_rdata          ),
      .l1_bypass_req_o    ( l1_bypass_req    ),
      .l1_flush_req_o     ( l1_flush_req     ),
      .l1_sel_flush_req_o ( l1_sel_flush_req ),
      .l1_bypass_ack_i    ( l1_bypass_ack    ),
      .l1_flush_ack_i     ( l1_flush_ack     ),
      .l1_sel_flush_ack_i ( l1_sel_flush_ack ),
      .l2_enable_req_o    ( l2_enable_req    ),
      .l2_disable_req_o   ( l2_disable_req   ),
      .l2_flush_req_o     ( l2_flush_req     ),
      .l2_sel_flush_req_o ( l2_sel_flush_req ),
      .l2_enable_ack_i    ( l2_enable_ack    ),
      .l2_disable_ack_i   ( l2_disable_ack   ),
      .l2_flush_ack_i     ( l2_flush_ack     ),
      .l2_sel_flush_ack_i ( l2_sel_flush_ack ),
      .sel_flush_addr_o   ( sel_flush_addr   ),
      .prefetch_en_o      ( prefetch_en      ),
      .special_cfg_o      ( special_cfg      )
   );

   ack_responder #(.WIDTH(NB_CORES)) u_l1_bypass_resp (clk, l1_bypass_req, l1_bypass_ack);
   ack_responder #(.WIDTH(NB_CORES)) u_l1_flush_resp (clk, l1_flush_req, l1_flush_ack);
   ack_responder #(.WIDTH(NB_CORES)) u_l1_sel_resp (clk, l1_sel_flush_req, l1_sel_flush_ack);
   ack_responder #(.WIDTH(NB_BANKS)) u_l2_enable_resp (clk, l2_enable_req, l2_enable_ack);
   ack_responder #(.WIDTH(NB_BANKS)) u_l2_disable_resp (clk, l2_disable_req, l2_disable_ack);
   ack_responder #(.WIDTH(NB_BANKS)) u_l2_flush_resp (clk, l2_flush_req, l2_flush_ack);
   ack_responder #(.WIDTH(NB_BANKS)) u_l2_sel_resp (clk, l2_sel_flush_req, l2_sel_flush_ack);

   function automatic logic is_mapped(input logic [3:0] offset);
      return offset inside {REG_ENABLE, REG_FLUSH_L2, REG_FLUSH_L1, REG_SEL_FLUSH,
                            REG_BYPASS, REG_PREFETCH, REG_SPECIAL};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timeout at %0d ns: %s", $time, what);
      hung = 1'b1;
      errors++;
   endtask

   // One port access with the grant and the response each awaited under a timeout
   task automatic bus_access(input logic write, input logic [3:0] offset,
                             input logic [31:0] data, input logic [3:0] bytes,
                             output logic [31:0] rdata);
      int cycles;
      @(negedge clk);
      req   = 1'b1;
      wen   = ~write;
      addr  = {26'd0, offset, 2'b00};
      wdata = data;
      be    = bytes;
      id++;
      cycles = 0;
      while (!granted && !hung)
      begin
         @(negedge clk);
         cycles++;
         if (cycles == 200)
         begin
            timed_out("no grant on the register port");
         end
      end
      req = 1'b0;
      cycles = 0;
      while (!r_valid && !hung)
      begin
         @(negedge clk);
         cycles++;
         if (cycles == 200)
         begin
            timed_out("no response after the grant");
         end
      end
      check_value("r_id_o", 32'(r_id), 32'(id));
      check_value("r_opc_o", 32'(r_opc), 32'(!is_mapped(offset)));
      rdata = r_rdata;
   endtask

   task automatic write_reg(input logic [3:0] offset, input logic [31:0] data,
                            input logic [3:0] bytes);
      logic [31:0] rdata;
      bus_access(1'b1, offset, data, bytes, rdata);
      check_value("r_rdata_o", rdata, 32'd0);
   endtask

   task automatic read_check(input logic [3:0] offset, input logic [31:0] exp);
      logic [31:0] rdata;
      bus_access(1'b0, offset, 32'd0, 4'h0, rdata);
      check_value("r_rdata_o", rdata, exp);
   endtask

   // Requests rise on the edge after the response cycle
   task automatic check_requests(input logic [NB_CORES-1:0] byp,
                                 input logic [NB_CORES-1:0] fl1,
                                 input logic [NB_CORES-1:0] sel1,
                                 input logic [NB_BANKS-1:0] en,
                                 input logic [NB_BANKS-1:0] dis,
                                 input logic [NB_BANKS-1:0] fl2,
                                 input logic [NB_BANKS-1:0] sel2);
      @(negedge clk);
      check_value("l1_bypass_req_o", 32'(l1_bypass_req), 32'(byp));
      check_value("l1_flush_req_o", 32'(l1_flush_req), 32'(fl1));
      check_value("l1_sel_flush_req_o", 32'(l1_sel_flush_req), 32'(sel1));
      check_value("l2_enable_req_o", 32'(l2_enable_req), 32'(en));
      check_value("l2_disable_req_o", 32'(l2_disable_req), 32'(dis));
      check_value("l2_flush_req_o", 32'(l2_flush_req), 32'(fl2));
      check_value("l2_sel_flush_req_o", 32'(l2_sel_flush_req), 32'(sel2));
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while ((|{l1_bypass_req, l1_flush_req, l1_sel_flush_req, l2_enable_req,
                l2_disable_req, l2_flush_req, l2_sel_flush_req}) && !hung)
      begin
         @(negedge clk);
         cycles++;
         if (cycles == 200)
         begin
            timed_out("cache requests never retired");
         end
      end
   endtask

   task automatic write_config(input logic [3:0] offset, input logic [31:0] data,
                               input logic [3:0] bytes);
      write_reg(offset, data, bytes);
      if (offset == REG_PREFETCH && bytes[0])
      begin
         pf_exp = data[NB_CORES-1:0];
      end
      if (offset == REG_SPECIAL && bytes[0])
      begin
         sp_exp = data[0];
      end
      check_value("prefetch_en_o", 32'(prefetch_en), 32'(pf_exp));
      check_value("special_cfg_o", 32'(special_cfg), 32'(sp_exp));
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
      begin
         $display("PASS %s", name);
      end
      else
      begin
         $display("FAIL %s", name);
         tests_failed++;
      end
      errors_at_start = errors;
   endtask

   initial
   begin
      logic [NB_BANKS-1:0] bank_mask;
      logic [NB_CORES-1:0] core_mask;
      logic [NB_CORES-1:0] bypass_mask;
      logic [31:0]         flush_addr;
      void'($urandom(32'ha941));
      arst_n = 1'b0;
      req    = 1'b0;
      wen    = 1'b1;
      addr   = '0;
      wdata  = '0;
      be     = '0;
      id     = '0;
      pf_exp = '0;
      sp_exp = 1'b0;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      read_check(REG_ENABLE, 32'd0);
      read_check(REG_PREFETCH, 32'd0);
      read_check(REG_SPECIAL, 32'd0);
      check_requests('0, '0, '0, '0, '0, '0, '0);
      end_test("reset defaults");

      bank_mask = 4'($urandom);
      write_reg(REG_ENABLE, 32'(bank_mask), 4'hf);
      check_requests('0, '0, '0, bank_mask, ~bank_mask, '0, '0);
      wait_idle();
      read_check(REG_ENABLE, 32'(bank_mask));
      end_test("bank enable mask");

      write_reg(REG_FLUSH_L2, 32'd1, 4'hf);
      check_requests('0, '0, '0, '0, '0, '1, '0);
      wait_idle();
      core_mask = 8'($urandom);
      write_reg(REG_FLUSH_L1, 32'(core_mask), 4'hf);
      check_requests('0, core_mask, '0, '0, '0, '0, '0);
      wait_idle();
      bypass_mask = 8'($urandom);
      write_reg(REG_BYPASS, 32'(bypass_mask), 4'hf);
      check_requests(bypass_mask, '0, '0, '0, '0, '0, '0);
      wait_idle();
      read_check(REG_BYPASS, 32'(bypass_mask));
      end_test("flush and bypass commands");

      flush_addr = $urandom() & 32'hffff_fffc;
      write_reg(REG_SEL_FLUSH, flush_addr, 4'hf);
      check_requests('0, '0, '1, '0, '0, '0, '1);
      check_value("sel_flush_addr_o", sel_flush_addr, flush_addr);
      wait_idle();
      end_test("selective flush");

      write_config(REG_PREFETCH, 32'h0000_00a5, 4'h1);
      write_config(REG_PREFETCH, 32'h0000_5a3c, 4'he);
      write_config(REG_PREFETCH, 32'h0000_ff3c, 4'h3);
      write_config(REG_SPECIAL, 32'd1, 4'h1);
      write_config(REG_SPECIAL, 32'd0, 4'h0);
      read_check(REG_SPECIAL, 32'(sp_exp));
      write_config(REG_SPECIAL, 32'd0, 4'h1);
      read_check(REG_PREFETCH, 32'(pf_exp));
      end_test("prefetch and special configuration");

      read_check(4'd5, 32'd0);
      write_config(4'd12, 32'hffff_ffff, 4'hf);
      check_requests('0, '0, '0, '0, '0, '0, '0);
      // Each access below is held off until the command before it retires
      write_reg(REG_FLUSH_L1, 32'hff, 4'h1);
      write_reg(REG_BYPASS, 32'(bypass_mask ^ 8'h0f), 4'h1);
      read_check(REG_BYPASS, 32'(bypass_mask ^ 8'h0f));
      write_reg(REG_FLUSH_L2, 32'd1, 4'hf);
      read_check(REG_PREFETCH, 32'(pf_exp));
      wait_idle();
      end_test("unmapped offsets and back-to-back accesses");

      $display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, u_dut.u_props.fail_count);
      if (errors == 0 && !hung && u_dut.u_props.fail_count == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// Cache-side model that gives each request line one ack pulse after a random delay of 1 to 6 cycles
module ack_responder #(parameter int WIDTH = 1)
(
   input  logic             clk_i,
   input  logic [WIDTH-1:0] req_i,
   output logic [WIDTH-1:0] ack_o
);
   timeunit 1ns;
   timeprecision 100ps;

   for (genvar i = 0; i < WIDTH; i++)
   begin : g_line
      logic ack_q;

      assign ack_o[i] = ack_q;

      initial
      begin
         int unsigned delay;
         ack_q = 1'b0;
         forever
         begin
            @(negedge clk_i);
            if (req_i[i])
            begin
               delay = 1 + ($urandom % 6);
               repeat (delay - 1) @(negedge clk_i);
               ack_q = 1'b1;
               @(negedge clk_i);
               ack_q = 1'b0;
            end
         end
      end
   end

endmodule

// ==== sim.f ====
hdl/icache_ctrl_pkg.sv
hdl/icache_ctrl_regs.sv
hdl/icache_ctrl_seq.sv
hdl/icache_ctrl_top.sv
test/icache_ctrl_props.sv
test/icache_ctrl_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction cache control unit

TOP := icache_ctrl_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
